/* vlog.f */
rtl/legCtrlPkg.sv
rtl/instrDecoder.sv
rtl/condCheck.sv
rtl/storeMask.sv
rtl/flagsReg.sv
rtl/controller.sv
test/controllerTb.sv

/* Bender.yml */
package:
  name: leg_ctrl

sources:
  - rtl/legCtrlPkg.sv
  - rtl/instrDecoder.sv
  - rtl/condCheck.sv
  - rtl/storeMask.sv
  - rtl/flagsReg.sv
  - rtl/controller.sv
  - target: test
    files:
      - test/controllerTb.sv

/* test/controllerTb.sv */
/*
  Testbench for the control pipeline top level.
  Drives random instructions from the kept classes, undefined encodings,
  random ALU flags and addresses, and stall and flush pulses. An in-order
  model tracks the instructions in Execute, Memory and Writeback and
  predicts every control output and the NZCV flags.
*/
module controllerTb;
  timeunit 1ns;
  timeprecision 1ps;

  import legCtrlPkg::*;

  localparam int NumInstr     = 400;
  localparam int DrainTimeout = 20;               // Cycles allowed to empty the pipeline
  localparam logic [31:0] NopNever = 32'hF000_0000; // Condition 1111 never executes

  // Expected state of one instruction in the pipeline
  typedef struct packed {
    logic        valid;
    logic        flushed;
    logic [31:0] instr;
    logic [3:0]  aluOp;
    logic        aluSrc;
    logic        branchTaken;
    logic        memWrite;
    logic        memtoReg;
    logic        regWrite;
    logic        pcSrc;
    logic [3:0]  mask;
    logic        setFlags;
    logic [3:0]  flagsAfter;
  } slotT;

  logic        clk;
  logic        reset;
  logic        stall;
  logic        flushE;
  instrT       instrD;
  flagsT       aluFlagsE;
  logic [31:0] aluResultE;
  aluOpT       aluControlE;
  logic        aluSrcE;
  logic        branchTakenE;
  logic        memWriteM;
  byteMaskT    byteMaskM;
  logic        memtoRegW;
  logic        regWriteW;
  logic        pcSrcW;
  flagsT       flags;

  logic [31:0] rngState = 32'h461d_a972;
  slotT        pipe[$];        // [0] Execute, [1] Memory, [2] Writeback
  logic [3:0]  specFlags;      // Flags after every instruction past Execute
  logic [3:0]  committedFlags; // Flags after every retired instruction
  logic        draining;
  int          inFlight;
  int          errors;
  int          checks;

  controller uut (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .flushE       (flushE),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .aluResultE   (aluResultE),
    .aluControlE  (aluControlE),
    .aluSrcE      (aluSrcE),
    .branchTakenE (branchTakenE),
    .memWriteM    (memWriteM),
    .byteMaskM    (byteMaskM),
    .memtoRegW    (memtoRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .flags        (flags)
  );

  always #20 clk = ~clk; // 40 ns period

  function automatic logic [31:0] nextRand();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  // ==================================================
  // Reference model
  // ==================================================
  // One instruction through Decode and Execute from the flags before it
  function automatic slotT predictSlot(logic [31:0] instr, logic flushed, logic [3:0] flagsIn,
                                       logic [3:0] aluFlags, logic [31:0] aluResult);
    slotT       s;
    logic [3:0] op;
    logic       isCmp;
    logic       rw;
    logic       mw;
    logic       br;
    logic       sets;
    logic       nzOnly;
    logic       base;
    logic       pass;
    s          = '0;
    s.valid    = 1'b1;
    s.flushed  = flushed;
    s.instr    = instr;
    s.aluOp    = 4'h4;         // ADD when nothing else applies
    s.flagsAfter = flagsIn;
    op     = instr[24:21];
    isCmp  = (op[3:2] == 2'b10); // TST TEQ CMP CMN
    rw     = 1'b0;
    mw     = 1'b0;
    br     = 1'b0;
    sets   = 1'b0;
    nzOnly = 1'b0;
    case (instr[27:26])
      2'b00: begin
        // Reg-by-reg shift space and compares without S are not kept
        if ((instr[25] || !instr[4]) && !(isCmp && !instr[20])) begin
          s.aluOp  = op;
          s.aluSrc = instr[25];
          rw       = !isCmp;
          sets     = instr[20];
          nzOnly   = !(op inside {4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hA, 4'hB});
        end
      end
      2'b01: begin
        if (!(instr[25] && instr[4])) begin
          s.aluOp    = instr[23] ? 4'h4 : 4'h2;  // U set adds and U clear subtracts
          s.aluSrc   = !instr[25];
          rw         = instr[20];
          mw         = !instr[20];
          s.memtoReg = instr[20];
          if (instr[22]) begin
            s.mask[aluResult[1:0]] = 1'b1;      // Byte store enables its own lane
          end else begin
            s.mask = 4'b1111;
          end
        end
      end
      2'b10: begin
        if (instr[25] && !instr[24]) begin        // B without link
          br       = 1'b1;
          s.aluSrc = 1'b1;
        end
      end
      default: ;
    endcase
    // Bit 28 inverts the base test of a condition pair so 1111 never passes
    case (instr[31:29])
      3'd0: base = flagsIn[2];
      3'd1: base = flagsIn[1];
      3'd2: base = flagsIn[3];
      3'd3: base = flagsIn[0];
      3'd4: base = flagsIn[1] && !flagsIn[2];
      3'd5: base = (flagsIn[3] == flagsIn[0]);
      3'd6: base = !flagsIn[2] && (flagsIn[3] == flagsIn[0]);
      default: base = 1'b1;
    endcase
    pass = instr[28] ? !base : base;
    if (flushed || !pass) begin
      rw         = 1'b0;
      mw         = 1'b0;
      br         = 1'b0;
      sets       = 1'b0;
      s.memtoReg = 1'b0;
    end
    s.regWrite    = rw;
    s.memWrite    = mw;
    s.branchTaken = br;
    s.pcSrc       = br || (rw && instr[15:12] == 4'd15);
    s.setFlags    = sets;
    if (sets) begin
      s.flagsAfter = nzOnly ? {aluFlags[3:2], flagsIn[1:0]} : aluFlags;
    end
    return s;
  endfunction

  task automatic checkValue(string what, logic [3:0] got, logic [3:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic driveRandom();
    logic [31:0] r;
    logic [31:0] word;
    r    = nextRand();
    word = nextRand();
    case (r[2:0])
      3'd0, 3'd1, 3'd2: word[27:26] = 2'b00;  // Data processing
      3'd3, 3'd4:       word[27:26] = 2'b01;  // LDR/STR
      3'd5: begin
        word[27:24] = 4'b1010;                // Plain B
      end
      default: ;                              // Raw word that is often undefined
    endcase
    if (r[4:3] == 2'd0) word[31:28] = 4'hE;   // Extra AL
    if (r[6:5] == 2'd0) word[15:12] = 4'hF;   // Extra R15 writes
    instrD     = word;
    aluFlagsE  = r[11:8];
    aluResultE = nextRand();
    stall      = (r[15:13] == 3'd0);
    flushE     = (r[18:16] == 3'd0);
  endtask

  // ==================================================
  // Checker sampling late in each cycle
  // ==================================================
  initial begin : compareOutputs
    slotT expE;
    slotT newE;
    forever begin
      @(posedge clk);
      #25;
      if (!reset) begin
        expE = pipe[0].valid ? predictSlot(pipe[0].instr, pipe[0].flushed, specFlags,
                                           aluFlagsE, aluResultE) : '0;
        if (expE.valid && !expE.flushed) begin
          checkValue("aluControlE", aluControlE, expE.aluOp);
          checkValue("aluSrcE", aluSrcE, expE.aluSrc);
        end
        checkValue("branchTakenE", branchTakenE, expE.branchTaken);
        checkValue("memWriteM", memWriteM, pipe[1].memWrite);
        if (pipe[1].memWrite) checkValue("byteMaskM", byteMaskM, pipe[1].mask);
        checkValue("regWriteW", regWriteW, pipe[2].regWrite);
        checkValue("memtoRegW", memtoRegW, pipe[2].memtoReg);
        checkValue("pcSrcW", pcSrcW, pipe[2].pcSrc);
        checkValue("flags", flags, committedFlags);
        if (!stall) begin              // Next edge moves every stage
          if (pipe[2].setFlags) committedFlags = pipe[2].flagsAfter;
          if (expE.setFlags) specFlags = expE.flagsAfter;
          newE = '0;
          if (!draining) begin
            newE.valid   = 1'b1;
            newE.instr   = instrD;
            newE.flushed = flushE;
          end
          void'(pipe.pop_back());
          pipe[0] = expE;
          pipe.push_front(newE);
          inFlight = pipe[0].valid + pipe[1].valid + pipe[2].valid;
        end
      end
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================
  initial begin : driveStimulus
    int waitCycles;
    clk            = 1'b0;
    reset          = 1'b1;
    stall          = 1'b0;
    flushE         = 1'b0;
    instrD         = NopNever;
    aluFlagsE      = '0;
    aluResultE     = '0;
    specFlags      = '0;
    committedFlags = '0;
    draining       = 1'b0;
    inFlight       = 0;
    errors         = 0;
    checks         = 0;
    pipe           = '{'0, '0, '0};
    repeat (2) @(posedge clk);
    #5;
    reset = 1'b0;
    for (int i = 0; i < NumInstr; i++) begin
      driveRandom();
      @(posedge clk);
      #5;
    end
    // Drain with never-executing bubbles
    draining   = 1'b1;
    instrD     = NopNever;
    stall      = 1'b0;
    flushE     = 1'b0;
    waitCycles = 0;
    while (inFlight != 0 && waitCycles < DrainTimeout) begin
      @(posedge clk);
      #5;
      waitCycles++;
    end
    if (inFlight != 0) begin
      errors++;
      $display("Pipeline did not drain within %0d cycles", DrainTimeout);
    end
    checkValue("final flags", flags, committedFlags);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* rtl/controller.sv */
/*
  Top level of the control pipeline (Decode, Execute, Memory, Writeback).
  Decodes instrD, carries the control bits down the stage registers and
  gates the register, memory and branch effects with the condition
  result in Execute. A hazard unit steers it: stall freezes every stage,
  flushE turns the instruction entering Execute into a bubble.
*/
module controller (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stall,         // Freezes all stage registers
  input  logic                 flushE,        // Bubble into Execute
  input  legCtrlPkg::instrT    instrD,
  input  legCtrlPkg::flagsT    aluFlagsE,
  input  logic [31:0]          aluResultE,    // Effective address for stores
  output legCtrlPkg::aluOpT    aluControlE,
  output logic                 aluSrcE,
  output logic                 branchTakenE,
  output logic                 memWriteM,
  output legCtrlPkg::byteMaskT byteMaskM,
  output logic                 memtoRegW,
  output logic                 regWriteW,
  output logic                 pcSrcW,
  output legCtrlPkg::flagsT    flags
);

  import legCtrlPkg::*;

  logic      regWriteD, memWriteD, memtoRegD, branchD, aluSrcD, pcSrcD, byteAccessD;
  aluOpT     aluControlD;
  flagWriteT flagWriteD;

  logic      regWriteE, memWriteE, memtoRegE, branchE, pcSrcE, byteAccessE;
  flagWriteT flagWriteE;
  condT      condE;
  logic      condExE, setFlagsE;
  flagsT     flagsE, flagsNextE;
  byteMaskT  byteMaskE;
  logic      regWriteGatedE, memWriteGatedE, memtoRegGatedE, pcSrcGatedE;

  logic      regWriteM, memtoRegM, pcSrcM, setFlagsM;
  flagsT     flagsNextM;

  logic      setFlagsW;
  flagsT     flagsNextW;

  // ==================================================
  // Decode
  // ==================================================
  instrDecoder decoder (
    .instr      (instrD),
    .regWrite   (regWriteD),
    .memWrite   (memWriteD),
    .memtoReg   (memtoRegD),
    .branch     (branchD),
    .aluSrc     (aluSrcD),
    .pcSrc      (pcSrcD),
    .aluControl (aluControlD),
    .flagWrite  (flagWriteD),
    .byteAccess (byteAccessD)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      memtoRegE   <= 1'b0;
      branchE     <= 1'b0;
      pcSrcE      <= 1'b0;
      flagWriteE  <= FlagWriteNone;
      aluControlE <= AluAdd;
      aluSrcE     <= 1'b0;
      byteAccessE <= 1'b0;
      condE       <= CcNv;  // Nothing executes out of reset
    end else if (!stall) begin
      // Flush only clears the enables
      regWriteE   <= regWriteD & ~flushE;
      memWriteE   <= memWriteD & ~flushE;
      memtoRegE   <= memtoRegD & ~flushE;
      branchE     <= branchD & ~flushE;
      pcSrcE      <= pcSrcD & ~flushE;
      flagWriteE  <= flagWriteD & {2{~flushE}};
      aluControlE <= aluControlD;
      aluSrcE     <= aluSrcD;
      byteAccessE <= byteAccessD;
      condE       <= condT'(instrD[CondHi:CondLo]);
    end
  end

  // ==================================================
  // Execute
  // ==================================================
  condCheck cond (
    .cond      (condE),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .flagWrite (flagWriteE),
    .condEx    (condExE),
    .flagsNext (flagsNextE),
    .setFlags  (setFlagsE)
  );

  storeMask lanes (
    .byteAccess (byteAccessE),
    .addrLow    (aluResultE[1:0]),
    .mask       (byteMaskE)
  );

  // Failed condition kills every effect
  assign branchTakenE   = branchE & condExE;
  assign regWriteGatedE = regWriteE & condExE;
  assign memWriteGatedE = memWriteE & condExE;
  assign memtoRegGatedE = memtoRegE & condExE; // No load from a skipped LDR
  assign pcSrcGatedE    = pcSrcE & condExE;

  always_ff @(posedge clk) begin
    if (reset) begin
      memWriteM  <= 1'b0;
      memtoRegM  <= 1'b0;
      regWriteM  <= 1'b0;
      pcSrcM     <= 1'b0;
      setFlagsM  <= 1'b0;
      byteMaskM  <= '0;
      flagsNextM <= '0;
    end else if (!stall) begin
      memWriteM  <= memWriteGatedE;
      memtoRegM  <= memtoRegGatedE;
      regWriteM  <= regWriteGatedE;
      pcSrcM     <= pcSrcGatedE;
      setFlagsM  <= setFlagsE;
      byteMaskM  <= byteMaskE;
      flagsNextM <= flagsNextE;
    end
  end

  // ==================================================
  // Memory to Writeback
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      memtoRegW  <= 1'b0;
      regWriteW  <= 1'b0;
      pcSrcW     <= 1'b0;
      setFlagsW  <= 1'b0;
      flagsNextW <= '0;
    end else if (!stall) begin
      memtoRegW  <= memtoRegM;
      regWriteW  <= regWriteM;
      pcSrcW     <= pcSrcM;
      setFlagsW  <= setFlagsM;
      flagsNextW <= flagsNextM;
    end
  end

  flagsReg nzcv (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .setFlagsM (setFlagsM),
    .flagsM    (flagsNextM),
    .setFlagsW (setFlagsW),
    .flagsW    (flagsNextW),
    .flagsE    (flagsE),
    .flags     (flags)
  );

  // Branch, store and load stay exclusive as an instruction moves down
  branchNotMemA: assert property (@(posedge clk) disable iff (reset)
    branchTakenE && !stall |=> !memWriteM && !memtoRegM)
    else $error("Taken branch reached Memory as a load or store");

  storeNotLoadA: assert property (@(posedge clk) disable iff (reset)
    memWriteM && !stall |=> !memtoRegW)
    else $error("Store in Memory reached Writeback as a load");

  holdUnderStallA: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable({aluControlE, aluSrcE, branchTakenE, memWriteM, byteMaskM,
                       memtoRegW, regWriteW, pcSrcW, flags}))
    else $error("Control outputs moved while stalled");

endmodule

/* rtl/flagsReg.sv */
/*
  Architectural NZCV register.
  Commits the Writeback copy of the flags at the edge that ends
  Writeback and forwards the newest pending flags back to Execute,
  so every instruction sees the flags of all older ones.
*/
module flagsReg (
  input  logic              clk,
  input  logic              reset,
  input  logic              stall,
  input  logic              setFlagsM,  // Instruction in Memory sets flags
  input  legCtrlPkg::flagsT flagsM,
  input  logic              setFlagsW,  // Instruction in Writeback sets flags
  input  legCtrlPkg::flagsT flagsW,
  output legCtrlPkg::flagsT flagsE,     // Forwarded to condCheck
  output legCtrlPkg::flagsT flags       // Committed flags
);

  import legCtrlPkg::*;

  // ==================================================
  // Committed flags
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (setFlagsW && !stall) begin
      flags <= flagsW;  // Writeback retires
    end
  end

  // ==================================================
  // Forwarding to Execute
  // ==================================================
  // Memory holds the younger of the two pending copies
  always_comb begin
    if (setFlagsM) begin
      flagsE = flagsM;
    end else if (setFlagsW) begin
      flagsE = flagsW;
    end else begin
      flagsE = flags;
    end
  end

endmodule

/* rtl/storeMask.sv */
/*
  Execute-stage byte-lane mask for stores.
  A word store writes all four lanes; a byte store writes the lane
  picked by the two low address bits from the ALU.
*/
module storeMask (
  input  logic                 byteAccess,
  input  logic [1:0]           addrLow,    // Low bits of the effective address
  output legCtrlPkg::byteMaskT mask
);

  import legCtrlPkg::*;

  byteMaskT laneSel;

  assign laneSel = byteMaskT'(4'b0001 << addrLow); // Little-endian lanes

  assign mask = byteAccess ? laneSel : 4'b1111;

  laneMaskA: assert final ($onehot(mask) || mask == 4'b1111)
    else $error("Store mask %b is neither one lane nor a full word", mask);

endmodule

/* rtl/condCheck.sv */
/*
  Execute-stage condition check.
  Evaluates the condition field of the instruction in Execute against
  the forwarded NZCV and builds the flags it leaves behind.
  Combinational; the top level registers flagsNext and setFlags.
*/
module condCheck (
  input  legCtrlPkg::condT      cond,
  input  legCtrlPkg::flagsT     flags,     // Newest flags from older instructions
  input  legCtrlPkg::flagsT     aluFlags,  // Flags from the ALU this cycle
  input  legCtrlPkg::flagWriteT flagWrite,
  output logic                  condEx,
  output legCtrlPkg::flagsT     flagsNext,
  output logic                  setFlags
);

  import legCtrlPkg::*;

  logic n;
  logic z;
  logic c;
  logic v;

  assign n = flags[FlagN];
  assign z = flags[FlagZ];
  assign c = flags[FlagC];
  assign v = flags[FlagV];

  // ==================================================
  // ARM condition table
  // ==================================================
  always_comb begin
    case (cond)
      CcEq:    condEx = z;
      CcNe:    condEx = ~z;
      CcCs:    condEx = c;
      CcCc:    condEx = ~c;
      CcMi:    condEx = n;
      CcPl:    condEx = ~n;
      CcVs:    condEx = v;
      CcVc:    condEx = ~v;
      CcHi:    condEx = c & ~z;          // Unsigned higher
      CcLs:    condEx = ~c | z;          // Unsigned lower or same
      CcGe:    condEx = (n == v);
      CcLt:    condEx = (n != v);
      CcGt:    condEx = ~z & (n == v);
      CcLe:    condEx = z | (n != v);
      CcAl:    condEx = 1'b1;
      default: condEx = 1'b0;            // 1111 never executes
    endcase
  end

  // ==================================================
  // Next flags
  // ==================================================
  // NZ and CV halves are merged separately
  assign flagsNext[FlagN:FlagZ] = flagWrite[1] ? aluFlags[FlagN:FlagZ] : flags[FlagN:FlagZ];
  assign flagsNext[FlagC:FlagV] = flagWrite[0] ? aluFlags[FlagC:FlagV] : flags[FlagC:FlagV];

  // A failed condition leaves the flags untouched
  assign setFlags = (flagWrite != FlagWriteNone) & condEx;

  neverExecutesA: assert final (!(condEx && cond == CcNv))
    else $error("Instruction with condition 1111 passed the condition check");

endmodule

/* rtl/instrDecoder.sv */
/*
  Decode-stage instruction decoder.
  Purely combinational: turns one 32-bit instruction into the control
  bits that travel down the pipeline. Anything outside data processing,
  word/byte LDR/STR and B comes out as a bubble with every enable low.
*/
module instrDecoder (
  input  legCtrlPkg::instrT     instr,
  output logic                  regWrite,
  output logic                  memWrite,
  output logic                  memtoReg,
  output logic                  branch,
  output logic                  aluSrc,     // 1 selects the immediate operand
  output logic                  pcSrc,
  output legCtrlPkg::aluOpT     aluControl,
  output legCtrlPkg::flagWriteT flagWrite,
  output logic                  byteAccess
);

  import legCtrlPkg::*;

  logic [1:0] opClass;
  aluOpT      dpOp;
  logic       isCompare;
  logic       dpSupported;
  logic       memSupported;
  logic       brSupported;
  logic       rdIsPc;

  assign opClass = instr[ClassHi:ClassLo];
  assign dpOp    = aluOpT'(instr[OpHi:OpLo]);
  assign rdIsPc  = (instr[RdHi:RdLo] == PcReg);

  // TST, TEQ, CMP, CMN only touch flags
  assign isCompare = (dpOp inside {AluTst, AluTeq, AluCmp, AluCmn});

  // ==================================================
  // Supported encodings
  // ==================================================
  // Register shifted by register shares its space with multiply
  // and the halfword transfers, all of them dropped
  // Compare opcodes without S are the misc space (MRS, MSR, BX, CLZ)
  assign dpSupported = (instr[IBit] | ~instr[RegShBit])
                     & ~(isCompare & ~instr[SBit]);

  assign memSupported = ~(instr[IBit] & instr[RegShBit]); // Else undefined
  assign brSupported  = instr[IBit] & ~instr[LinkBit];     // Plain B only, no BL, no LDM/STM

  // ==================================================
  // Control bits
  // ==================================================
  always_comb begin
    // Bubble defaults
    regWrite   = 1'b0;
    memWrite   = 1'b0;
    memtoReg   = 1'b0;
    branch     = 1'b0;
    aluSrc     = 1'b0;
    aluControl = AluAdd;
    flagWrite  = FlagWriteNone;
    byteAccess = 1'b0;

    case (opClass)
      ClassDp: begin
        if (dpSupported) begin
          aluSrc     = instr[IBit];  // Rotated immediate or register
          aluControl = dpOp;         // Opcode goes straight to the ALU
          regWrite   = ~isCompare;
          if (instr[SBit]) begin
            // Logical ops update NZ only
            flagWrite = isLogicalOp(dpOp) ? FlagWriteNz : FlagWriteAll;
          end
        end
      end

      ClassMem: begin
        if (memSupported) begin
          aluSrc     = ~instr[IBit];                   // I clear means 12-bit offset
          aluControl = instr[UBit] ? AluAdd : AluSub;  // Base plus or minus offset
          byteAccess = instr[BBit];
          if (instr[LBit]) begin
            regWrite = 1'b1;  // LDR
            memtoReg = 1'b1;
          end else begin
            memWrite = 1'b1;  // STR
          end
        end
      end

      ClassBr: begin
        if (brSupported) begin
          branch     = 1'b1;
          aluSrc     = 1'b1;  // PC plus shifted offset
          aluControl = AluAdd;
        end
      end

      default: begin
        // Coprocessor and SWI space stay a bubble
      end
    endcase
  end

  // Any register write to R15 redirects the PC, loads included
  assign pcSrc = branch | (regWrite & rdIsPc);

endmodule

/* rtl/legCtrlPkg.sv */
/*
  Shared definitions for the four-stage control pipeline.
  Holds the instruction field positions, the ALU opcode and condition
  code encodings and the flag types. Every RTL module imports it.
*/
package legCtrlPkg;

  typedef logic [31:0] instrT;     // Raw instruction word
  typedef logic [3:0]  flagsT;     // {N, Z, C, V}
  typedef logic [1:0]  flagWriteT; // [1] enables NZ, [0] enables CV
  typedef logic [3:0]  byteMaskT;  // One enable per byte lane

  // ARM condition codes, 1111 is never
  typedef enum logic [3:0] {
    CcEq = 4'b0000, CcNe, CcCs, CcCc,
    CcMi, CcPl, CcVs, CcVc,
    CcHi, CcLs, CcGe, CcLt,
    CcGt, CcLe, CcAl, CcNv
  } condT;

  // Data-processing opcodes, bits 24:21 of the instruction
  typedef enum logic [3:0] {
    AluAnd = 4'h0, AluEor, AluSub, AluRsb,
    AluAdd, AluAdc, AluSbc, AluRsc,
    AluTst, AluTeq, AluCmp, AluCmn,
    AluOrr, AluMov, AluBic, AluMvn
  } aluOpT;

  // Instruction field positions
  localparam int unsigned CondHi   = 31;
  localparam int unsigned CondLo   = 28;
  localparam int unsigned ClassHi  = 27; // 00 DP, 01 LDR/STR, 10 branch
  localparam int unsigned ClassLo  = 26;
  localparam int unsigned IBit     = 25; // Immediate select, also set for B
  localparam int unsigned OpHi     = 24;
  localparam int unsigned OpLo     = 21;
  localparam int unsigned LinkBit  = 24;
  localparam int unsigned UBit     = 23; // Offset added when set
  localparam int unsigned BBit     = 22; // Byte access
  localparam int unsigned SBit     = 20;
  localparam int unsigned LBit     = 20; // Load when set
  localparam int unsigned RdHi     = 15;
  localparam int unsigned RdLo     = 12;
  localparam int unsigned RegShBit = 4;  // Register-specified shift

  localparam logic [3:0] PcReg = 4'd15;

  localparam logic [1:0] ClassDp  = 2'b00;
  localparam logic [1:0] ClassMem = 2'b01;
  localparam logic [1:0] ClassBr  = 2'b10;

  // Flag bit positions inside flagsT
  localparam int unsigned FlagN = 3;
  localparam int unsigned FlagZ = 2;
  localparam int unsigned FlagC = 1;
  localparam int unsigned FlagV = 0;

  localparam flagWriteT FlagWriteNone = 2'b00;
  localparam flagWriteT FlagWriteNz   = 2'b10;
  localparam flagWriteT FlagWriteAll  = 2'b11;

  // Logical opcodes leave C and V alone here, no shifter carry
  function automatic logic isLogicalOp(aluOpT op);
    case (op)
      AluAnd, AluEor, AluTst, AluTeq,
      AluOrr, AluMov, AluBic, AluMvn: return 1'b1;
      default:                        return 1'b0;
    endcase
  endfunction

endpackage
